// ==== Bender.yml ====
package:
  name: audio_out_stage

sources:
  # RTL in compile order
  - verilog/audio_pkg.sv
  - verilog/stereo_if.sv
  - verilog/audio_regs.sv
  - verilog/source_mixer.sv
  - verilog/range_compressor.sv
  - verilog/stereo_blend.sv
  - verilog/audio_out_stage.sv

  # Checker and testbench
  - target: simulation
    files:
      - sim/audio_out_stage_chk.sv
      - sim/tb_audio_out_stage.sv

// ==== sim/audio_out_stage_chk.sv ====
// Protocol and latency properties of the stage top; assumes the stage never sees X on its strobes
`timescale 1ns/100ps

module audio_out_stage_chk (
	input logic clk_sys,
	input logic rst_n,
	input logic sample_valid,
	input logic out_valid,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	// Number of failed properties for the testbench summary
	int fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// Sample pipeline
	//////////////////////////////////////////////////////////////////////

	// Every accepted sample leaves after the fixed latency
	a_latency_fwd: assert property (@(posedge clk_sys) disable iff (!rst_n)
		sample_valid |-> ##(audio_pkg::PIPE_LATENCY) out_valid)
		else begin
			$error("out_valid missing after sample_valid");
			fail_cnt++;
		end

	// No output strobe without a matching input
	a_latency_back: assert property (@(posedge clk_sys) disable iff (!rst_n)
		out_valid |-> $past(sample_valid, audio_pkg::PIPE_LATENCY))
		else begin
			$error("out_valid without sample_valid");
			fail_cnt++;
		end

	//////////////////////////////////////////////////////////////////////
	// Wishbone handshake
	//////////////////////////////////////////////////////////////////////

	a_ack_in_cycle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(wb_ack) |-> wb_cyc && wb_stb && $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack outside a bus cycle");
			fail_cnt++;
		end

	// Single-cycle ack
	a_ack_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack held two cycles");
			fail_cnt++;
		end

	// Outputs quiet in reset
	a_reset_quiet: assert property (@(posedge clk_sys)
		!rst_n |-> !out_valid && !wb_ack)
		else begin
			$error("strobe high during reset");
			fail_cnt++;
		end

endmodule

bind audio_out_stage audio_out_stage_chk i_audio_out_stage_chk (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.sample_valid (sample_valid),
	.out_valid    (out_valid),
	.wb_cyc       (wb_cyc),
	.wb_stb       (wb_stb),
	.wb_ack       (wb_ack)
);

// ==== sim/tb_audio_out_stage.sv ====
// Random traffic checked against a behavioral model; control writes happen only with an empty pipeline
`timescale 1ns/100ps

module tb_audio_out_stage;

	logic               clk_sys;
	logic               rst_n;
	logic               sample_valid;
	audio_pkg::sample_t core_l;
	audio_pkg::sample_t core_r;
	audio_pkg::sample_t synth_l;
	audio_pkg::sample_t synth_r;
	logic               out_valid;
	audio_pkg::sample_t out_l;
	audio_pkg::sample_t out_r;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	logic               wb_adr;
	logic [15:0]        wb_dat_w;
	logic [15:0]        wb_dat_r;
	logic               wb_ack;

	// Result bookkeeping
	int          errors;
	int          checks;
	int          test_start_err;
	string       cur_test;
	logic [31:0] lcg_state;

	// Model copy of the last CTRL write
	int model_mix;
	int model_curve;
	int model_mute;
	int clip_model;
	int exp_l[$];
	int exp_r[$];

	audio_out_stage i_audio_out_stage (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Picks full-scale edges, both knees or plain random values
	function automatic int pick_sample();
		logic [31:0] r;
		logic [31:0] w;
		int          v;
		r = next_rand();
		w = next_rand();
		v = $signed(w[31:16]);
		case (r[31:29])
			3'd0: v = 32767 - int'(r[20:16]);
			3'd1: v = -32768 + int'(r[20:16]);
			3'd2: v = audio_pkg::GENTLE_X - 16 + int'(r[20:16]);
			3'd3: v = audio_pkg::STRONG_X - 16 + int'(r[20:16]);
			default: ;
		endcase
		if (r[31:29] inside {3'd2, 3'd3} && r[0])
			v = -v;
		return v;
	endfunction

	function automatic int saturate(input int s);
		if (s > 32767)
			return 32767;
		if (s < -32768)
			return -32768;
		return s;
	endfunction

	// Magnitude knee, clamp, then sign back on
	function automatic int compress(input int s, input int curve);
		int x;
		int a;
		int f;
		int b;
		int m;
		int r;
		if (curve == 1) begin
			x = audio_pkg::GENTLE_X; a = audio_pkg::GENTLE_A;
			f = audio_pkg::GENTLE_F; b = audio_pkg::GENTLE_B;
		end else if (curve == 2) begin
			x = audio_pkg::STRONG_X; a = audio_pkg::STRONG_A;
			f = audio_pkg::STRONG_F; b = audio_pkg::STRONG_B;
		end else begin
			return s;
		end
		m = (s < 0) ? -s : s;
		r = (m < x) ? m * a : (m - x) / f + b;
		if (r > audio_pkg::SAMPLE_MAX)
			r = audio_pkg::SAMPLE_MAX;
		return (s < 0) ? -r : r;
	endfunction

	// Floored weighted sums on 32-bit ints
	function automatic int blend(input int own, input int other, input int lvl);
		case (lvl)
			1: return (3 * own + other) >>> 2;
			2: return (5 * own + 3 * other) >>> 3;
			3: return (own + other) >>> 1;
			default: return own;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$finish;
	endtask

	// One classic cycle held until the slave acknowledges
	task automatic wb_access(input logic we, input logic adr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		int n;
		n = 0;
		@(posedge clk_sys);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > 20)
				abort_run("Timeout: the Wishbone slave never acknowledged the access");
		end while (!wb_ack);
		rdata = wb_dat_r;
		@(posedge clk_sys);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic set_ctrl(input int mix, input int curve, input int mute);
		logic [15:0] rd;
		wb_access(1'b1, audio_pkg::REG_CTRL, 16'((mute << audio_pkg::CTRL_MUTE_BIT) |
			(curve << audio_pkg::CTRL_CURVE_LSB) | (mix << audio_pkg::CTRL_MIX_LSB)), rd);
		model_mix   = mix;
		model_curve = curve;
		model_mute  = mute;
	endtask

	// Expected pair goes in the queue before the strobe is driven
	task automatic send_sample(input int cl, input int cr, input int sl, input int sr);
		int sum_l;
		int sum_r;
		int c_l;
		int c_r;
		sum_l = cl + (model_mute ? 0 : sl);
		sum_r = cr + (model_mute ? 0 : sr);
		if (sum_l != saturate(sum_l) || sum_r != saturate(sum_r))
			clip_model++;
		c_l = compress(saturate(sum_l), model_curve);
		c_r = compress(saturate(sum_r), model_curve);
		exp_l.push_back(blend(c_l, c_r, model_mix));
		exp_r.push_back(blend(c_r, c_l, model_mix));
		@(posedge clk_sys);
		sample_valid <= 1'b1;
		core_l       <= 16'(cl);
		core_r       <= 16'(cr);
		synth_l      <= 16'(sl);
		synth_r      <= 16'(sr);
	endtask

	task automatic end_samples();
		@(posedge clk_sys);
		sample_valid <= 1'b0;
	endtask

	// Burst keeps the strobe high and the other mode adds random gaps
	task automatic random_traffic(input int count, input bit burst);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			send_sample(pick_sample(), pick_sample(), pick_sample(), pick_sample());
			r = next_rand();
			if (!burst && r[27])
				end_samples();
		end
		end_samples();
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_l.size() != 0) begin
			@(negedge clk_sys);
			n++;
			if (n > 60)
				abort_run("Timeout: expected output samples never arrived");
		end
	endtask

	task automatic start_test(input string name);
		cur_test       = name;
		test_start_err = errors;
	endtask

	task automatic finish_test();
		$display("test %s done, %0d errors", cur_test, errors - test_start_err);
	endtask

	// Output monitor samples half a cycle after the DUT edge
	always @(negedge clk_sys) begin
		if (rst_n && out_valid) begin
			if (exp_l.size() == 0) begin
				errors++;
				$display("Output sample in test %s arrived with none expected", cur_test);
			end else begin
				check_value({cur_test, "_left"}, exp_l.pop_front(), out_l);
				check_value({cur_test, "_right"}, exp_r.pop_front(), out_r);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] rd;
		logic [31:0] r;
		rst_n        = 1'b1;
		sample_valid = 1'b0;
		core_l       = '0;
		core_r       = '0;
		synth_l      = '0;
		synth_r      = '0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = 1'b0;
		wb_dat_w     = '0;
		errors       = 0;
		checks       = 0;
		clip_model   = 0;
		model_mix    = 0;
		model_curve  = 0;
		model_mute   = 0;
		lcg_state    = 32'd98854;
		// Falling edge of rst_n once every register process waits on it
		rst_n <= 1'b0;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;

		start_test("reset_regs");
		wb_access(1'b0, audio_pkg::REG_CTRL, 16'h0, rd);
		check_value("ctrl_after_reset", 0, rd);
		wb_access(1'b0, audio_pkg::REG_CLIP, 16'h0, rd);
		check_value("clip_after_reset", 0, rd);
		r = next_rand();
		wb_access(1'b1, audio_pkg::REG_CTRL, r[31:16], rd);
		wb_access(1'b0, audio_pkg::REG_CTRL, 16'h0, rd);
		check_value("ctrl_mix", r[16 + audio_pkg::CTRL_MIX_LSB +: 2],
			rd[audio_pkg::CTRL_MIX_LSB +: 2]);
		check_value("ctrl_curve", r[16 + audio_pkg::CTRL_CURVE_LSB +: 2],
			rd[audio_pkg::CTRL_CURVE_LSB +: 2]);
		check_value("ctrl_mute", r[16 + audio_pkg::CTRL_MUTE_BIT], rd[audio_pkg::CTRL_MUTE_BIT]);
		finish_test();

		start_test("bypass_sum");
		set_ctrl(0, 0, 0);
		random_traffic(40, 1'b0);
		wait_drain();
		set_ctrl(0, 0, 1);
		random_traffic(40, 1'b0);
		wait_drain();
		finish_test();

		// Mute on so the compressor sees core audio directly
		start_test("compress");
		for (int c = 1; c <= 2; c++) begin
			set_ctrl(0, c, 1);
			send_sample(-32768, 32767, 0, 0);
			send_sample(audio_pkg::GENTLE_X, -audio_pkg::GENTLE_X + 1, 0, 0);
			send_sample(audio_pkg::STRONG_X - 1, -audio_pkg::STRONG_X, 0, 0);
			random_traffic(60, 1'b0);
			wait_drain();
		end
		finish_test();

		start_test("blend");
		for (int m = 0; m < 4; m++) begin
			set_ctrl(m, 0, 0);
			random_traffic(30, 1'b0);
			wait_drain();
		end
		finish_test();

		start_test("burst_clip");
		set_ctrl(2, 2, 0);
		random_traffic(64, 1'b1);
		wait_drain();
		wb_access(1'b0, audio_pkg::REG_CLIP, 16'h0, rd);
		check_value("clip_count", clip_model, rd);
		finish_test();

		// Property failures from the bound checker count as errors
		if (i_audio_out_stage.i_audio_out_stage_chk.fail_cnt != 0) begin
			$display("Bound checker saw %0d failed assertions",
				i_audio_out_stage.i_audio_out_stage_chk.fail_cnt);
			errors += i_audio_out_stage.i_audio_out_stage_chk.fail_cnt;
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/audio_pkg.sv
verilog/stereo_if.sv
verilog/audio_regs.sv
verilog/source_mixer.sv
verilog/range_compressor.sv
verilog/stereo_blend.sv
verilog/audio_out_stage.sv
sim/audio_out_stage_chk.sv
sim/tb_audio_out_stage.sv

// ==== verilog/audio_out_stage.sv ====
// Audio output stage top; out_valid trails sample_valid by PIPE_LATENCY cycles and nothing can stall it
`timescale 1ns/100ps

module audio_out_stage (
	input  logic                                clk_sys,
	input  logic                                rst_n,

	// Sample input, one pair per strobe
	input  logic                                sample_valid,
	input  audio_pkg::sample_t                  core_l,
	input  audio_pkg::sample_t                  core_r,
	input  audio_pkg::sample_t                  synth_l,
	input  audio_pkg::sample_t                  synth_r,

	// Processed output
	output logic                                out_valid,
	output audio_pkg::sample_t                  out_l,
	output audio_pkg::sample_t                  out_r,

	// Wishbone classic slave
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic                                wb_adr,
	input  logic [audio_pkg::WB_DATA_W-1:0]     wb_dat_w,
	output logic [audio_pkg::WB_DATA_W-1:0]     wb_dat_r,
	output logic                                wb_ack
);

	// Settings from the register block
	audio_pkg::mix_e    mix;
	audio_pkg::curve_e  curve;
	logic               mute;

	// Compressor outputs
	logic               comp_valid;
	audio_pkg::sample_t comp_l;
	audio_pkg::sample_t comp_r;

	// Mixer to compressors, also watched for clips
	stereo_if mix_bus ();

	audio_regs i_audio_regs (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.mix      (mix),
		.curve    (curve),
		.mute     (mute),
		.mon      (mix_bus.mon)
	);

	//////////////////////////////////////////////////////////////////////
	// Stage 1 sum, stage 2 compress, stage 3 blend
	//////////////////////////////////////////////////////////////////////

	source_mixer i_source_mixer (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.core_l       (core_l),
		.core_r       (core_r),
		.synth_l      (synth_l),
		.synth_r      (synth_r),
		.mute         (mute),
		.mix_out      (mix_bus.src)
	);

	// Left and right run in lockstep, left strobe drives the blend
	range_compressor i_comp_l (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.curve      (curve),
		.in_valid   (mix_bus.valid),
		.in_sample  (mix_bus.left),
		.out_valid  (comp_valid),
		.out_sample (comp_l)
	);

	range_compressor i_comp_r (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.curve      (curve),
		.in_valid   (mix_bus.valid),
		.in_sample  (mix_bus.right),
		.out_valid  (),
		.out_sample (comp_r)
	);

	stereo_blend i_stereo_blend (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.mix       (mix),
		.in_valid  (comp_valid),
		.in_l      (comp_l),
		.in_r      (comp_r),
		.out_valid (out_valid),
		.out_l     (out_l),
		.out_r     (out_r)
	);

endmodule

// ==== verilog/audio_pkg.sv ====
// Shared types and constants for the audio output stage; compressor knees assume 16-bit signed samples
package audio_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sample and option types
	//////////////////////////////////////////////////////////////////////

	// One signed PCM sample
	typedef logic signed [15:0] sample_t;

	// Compressor curve, code 3 is treated as bypass
	typedef enum logic [1:0] {
		CURVE_BYPASS = 2'd0,
		CURVE_GENTLE = 2'd1,
		CURVE_STRONG = 2'd2
	} curve_e;

	// Stereo blend level
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_e;

	//////////////////////////////////////////////////////////////////////
	// Wishbone register map
	//////////////////////////////////////////////////////////////////////

	localparam int WB_DATA_W = 16;

	// Word addresses
	typedef enum logic [0:0] {
		REG_CTRL = 1'b0,
		REG_CLIP = 1'b1
	} reg_addr_e;

	// CTRL fields
	localparam int CTRL_MIX_LSB   = 0;
	localparam int CTRL_CURVE_LSB = 2;
	localparam int CTRL_MUTE_BIT  = 4;

	//////////////////////////////////////////////////////////////////////
	// Compressor curves
	//////////////////////////////////////////////////////////////////////

	// Gentle: slope 2 below the knee, 1/4 above
	localparam int GENTLE_F = 4;
	localparam int GENTLE_A = 2;
	localparam int GENTLE_X = 14044;
	localparam int GENTLE_B = 28088;

	// Strong: slope 4 below the knee, 1/8 above
	localparam int STRONG_F = 8;
	localparam int STRONG_A = 4;
	localparam int STRONG_X = 7400;
	localparam int STRONG_B = 29600;

	// Largest magnitude leaving the compressor
	localparam int SAMPLE_MAX = 32767;

	// Mixer, compressor and blend each add one register
	localparam int PIPE_LATENCY = 3;

endpackage

// ==== verilog/audio_regs.sv ====
// Wishbone classic slave with single-cycle ack, no wait states beyond one cycle and no error response
`timescale 1ns/100ps

module audio_regs (
	input  logic                                clk_sys,
	input  logic                                rst_n,
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic                                wb_adr,
	input  logic [audio_pkg::WB_DATA_W-1:0]     wb_dat_w,
	output logic [audio_pkg::WB_DATA_W-1:0]     wb_dat_r,
	output logic                                wb_ack,
	output audio_pkg::mix_e                     mix,
	output audio_pkg::curve_e                   curve,
	output logic                                mute,
	stereo_if.mon                               mon
);

	// CTRL holds mix, curve and mute
	logic [audio_pkg::CTRL_MUTE_BIT:0] ctrl_q;
	logic [audio_pkg::WB_DATA_W-1:0]   clip_cnt;
	audio_pkg::reg_addr_e              addr;
	logic                              wb_req;

	assign addr = audio_pkg::reg_addr_e'(wb_adr);

	// New request, ack low keeps back-to-back acks apart
	assign wb_req = wb_cyc & wb_stb & ~wb_ack;

	//////////////////////////////////////////////////////////////////////
	// Bus handshake and CTRL register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			ctrl_q <= '0;
		end else begin
			wb_ack <= wb_req;
			// Writes to the clip counter are dropped
			if (wb_req && wb_we && addr == audio_pkg::REG_CTRL)
				ctrl_q <= wb_dat_w[audio_pkg::CTRL_MUTE_BIT:0];
		end
	end

	// Read data captured on the acknowledging edge
	always_ff @(posedge clk_sys) begin
		if (wb_req) begin
			case (addr)
				audio_pkg::REG_CTRL: wb_dat_r <= audio_pkg::WB_DATA_W'(ctrl_q);
				default:             wb_dat_r <= clip_cnt;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Clip counter
	//////////////////////////////////////////////////////////////////////

	// Counts clipped mixer samples, sticks at all ones
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clip_cnt <= '0;
		end else if (mon.valid && mon.clip && clip_cnt != '1) begin
			clip_cnt <= clip_cnt + 1'b1;
		end
	end

	// Field decode
	assign mix   = audio_pkg::mix_e'(ctrl_q[audio_pkg::CTRL_MIX_LSB +: 2]);
	assign curve = audio_pkg::curve_e'(ctrl_q[audio_pkg::CTRL_CURVE_LSB +: 2]);
	assign mute  = ctrl_q[audio_pkg::CTRL_MUTE_BIT];

endmodule

// ==== verilog/range_compressor.sv ====
// Piecewise-linear compressor for one channel; F and A are powers of two so the divide is a shift
`timescale 1ns/100ps

module range_compressor (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  audio_pkg::curve_e  curve,
	input  logic               in_valid,
	input  audio_pkg::sample_t in_sample,
	output logic               out_valid,
	output audio_pkg::sample_t out_sample
);

	logic [15:0]        mag;
	logic [15:0]        mag_c;
	audio_pkg::sample_t comp;

	// Magnitude mapping for one curve, result clamped to full scale
	function automatic logic [15:0] knee(
		input logic [15:0] m,
		input int          x,
		input int          a,
		input int          f,
		input int          b
	);
		logic [17:0] mw;
		logic [17:0] r;
		mw = {2'b00, m};
		if (mw < 18'(x))
			r = mw * 18'(a);
		else
			r = (mw - 18'(x)) / 18'(f) + 18'(b);
		// Top of the range lands a few counts above 32767
		knee = (r > 18'(audio_pkg::SAMPLE_MAX)) ? 16'(audio_pkg::SAMPLE_MAX) : r[15:0];
	endfunction

	// 0x8000 gives magnitude 32768, fits unsigned
	assign mag = in_sample[15] ? 16'(-in_sample) : in_sample;

	always_comb begin
		mag_c = mag;
		case (curve)
			audio_pkg::CURVE_GENTLE: mag_c = knee(mag, audio_pkg::GENTLE_X,
				audio_pkg::GENTLE_A, audio_pkg::GENTLE_F, audio_pkg::GENTLE_B);
			audio_pkg::CURVE_STRONG: mag_c = knee(mag, audio_pkg::STRONG_X,
				audio_pkg::STRONG_A, audio_pkg::STRONG_F, audio_pkg::STRONG_B);
			default: mag_c = mag;
		endcase
		// Bypass and the spare code keep the raw sample
		if (curve == audio_pkg::CURVE_GENTLE || curve == audio_pkg::CURVE_STRONG)
			comp = in_sample[15] ? -$signed(mag_c) : $signed(mag_c);
		else
			comp = in_sample;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// Payload held between strobes
	always_ff @(posedge clk_sys) begin
		if (in_valid)
			out_sample <= comp;
	end

endmodule

// ==== verilog/source_mixer.sv ====
// Core plus synthesizer sum per channel; saturates instead of wrapping, data only loads on a valid cycle
`timescale 1ns/100ps

module source_mixer (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               sample_valid,
	input  audio_pkg::sample_t core_l,
	input  audio_pkg::sample_t core_r,
	input  audio_pkg::sample_t synth_l,
	input  audio_pkg::sample_t synth_r,
	input  logic               mute,
	stereo_if.src              mix_out
);

	audio_pkg::sample_t syn_l;
	audio_pkg::sample_t syn_r;
	logic signed [16:0] sum_l;
	logic signed [16:0] sum_r;
	logic               clip_l;
	logic               clip_r;

	// Clamp a 17-bit sum into the sample range
	function automatic audio_pkg::sample_t sat16(input logic signed [16:0] s);
		if (s[16] != s[15])
			sat16 = s[16] ? ~16'(audio_pkg::SAMPLE_MAX) : 16'(audio_pkg::SAMPLE_MAX);
		else
			sat16 = s[15:0];
	endfunction

	// Muted synth adds nothing
	assign syn_l = mute ? '0 : synth_l;
	assign syn_r = mute ? '0 : synth_r;

	// One guard bit is enough for two addends
	assign sum_l = core_l + syn_l;
	assign sum_r = core_r + syn_r;

	// Sign bits disagree on overflow
	assign clip_l = sum_l[16] ^ sum_l[15];
	assign clip_r = sum_r[16] ^ sum_r[15];

	// Strobe and clip flag
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mix_out.valid <= 1'b0;
			mix_out.clip  <= 1'b0;
		end else begin
			mix_out.valid <= sample_valid;
			mix_out.clip  <= sample_valid & (clip_l | clip_r);
		end
	end

	// Sample payload
	always_ff @(posedge clk_sys) begin
		if (sample_valid) begin
			mix_out.left  <= sat16(sum_l);
			mix_out.right <= sat16(sum_r);
		end
	end

endmodule

// ==== verilog/stereo_blend.sv ====
// Cross-feed of left and right at four fixed levels; every weighted sum is floored, never rounded
`timescale 1ns/100ps

module stereo_blend (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  audio_pkg::mix_e    mix,
	input  logic               in_valid,
	input  audio_pkg::sample_t in_l,
	input  audio_pkg::sample_t in_r,
	output logic               out_valid,
	output audio_pkg::sample_t out_l,
	output audio_pkg::sample_t out_r
);

	audio_pkg::sample_t blend_l;
	audio_pkg::sample_t blend_r;

	// Weighted mix of own and other channel
	function automatic audio_pkg::sample_t blend(
		input audio_pkg::sample_t own,
		input audio_pkg::sample_t other,
		input audio_pkg::mix_e    lvl
	);
		logic signed [19:0] o;
		logic signed [19:0] t;
		logic signed [19:0] acc;
		// 20 bits covers 8 x full scale
		o = own;
		t = other;
		case (lvl)
			audio_pkg::MIX_25:   acc = (3 * o + t) >>> 2;
			audio_pkg::MIX_50:   acc = (5 * o + 3 * t) >>> 3;
			audio_pkg::MIX_MONO: acc = (o + t) >>> 1;
			default:             acc = o;
		endcase
		// Weights sum to one so the result is back in range
		blend = acc[15:0];
	endfunction

	// Same rule for both sides with roles swapped
	assign blend_l = blend(in_l, in_r, mix);
	assign blend_r = blend(in_r, in_l, mix);

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_l     <= '0;
			out_r     <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				out_l <= blend_l;
				out_r <= blend_r;
			end
		end
	end

endmodule

// ==== verilog/stereo_if.sv ====
// One stereo sample per valid cycle with no back-pressure; the clip flag only means something when valid is high
`timescale 1ns/100ps

interface stereo_if;

	// Sample strobe, one sample per high cycle
	logic valid;

	// Channel payload
	audio_pkg::sample_t left;
	audio_pkg::sample_t right;

	// Either channel saturated in the sum
	logic clip;

	// Producer side, the source mixer
	modport src (
		output valid,
		output left,
		output right,
		output clip
	);

	// Consumer of the sample pair
	modport dst (
		input valid,
		input left,
		input right
	);

	// Register block watches strobe and clip only
	modport mon (
		input valid,
		input clip
	);

endinterface
